// File: flist.f
+incdir+include
hw/fpu_pkg.sv
hw/fp_sign_lane.sv
hw/fp_compare_lane.sv
hw/fp_completion_queue.sv
hw/fp_unit_wrapper.sv
testbench/tb_fp_unit_wrapper.sv

// File: Makefile
# Verilator build and run of the FP unit testbench
# Override any variable on the command line, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_fp_unit_wrapper
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS RUN_ARGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The simulator exits non-zero on $$fatal, so make fails with it
test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_fp_unit_wrapper.sv
// Self-checking testbench for the FP unit top level
// A reference model fills a scoreboard at each accepted instruction and
// assertions compare every writeback with its front entry
`default_nettype none

`include "fpu_config.svh"

module tb_fp_unit_wrapper
   import fpu_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_RANDOM  = 200;
   localparam int WATCHDOG_NS = (NUM_RANDOM + 11 * 10 + 60) * 20 * 10;
   localparam logic [31:0] SPECIAL [10] = '{
      32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h0000_0001,
      32'h807F_FFFF, 32'h7F80_0001, 32'hFFC0_0001, 32'h3F80_0000, 32'hC000_0000
   };

   logic                       clk_i, arst_n_i, kill_i, stall_wb_i, instr_valid_i;
   fp_op_e                     instr_op_i;
   logic [`FPU_XLEN-1:0]       rs1_data_i, rs2_data_i;
   logic [`FPU_REG_ADDR_W-1:0] rd_i;
   logic                       stall_o, fp_wb_valid_o, int_wb_valid_o, wb_nv_o;
   logic [`FPU_REG_ADDR_W-1:0] wb_rd_o;
   logic [`FPU_XLEN-1:0]       wb_result_o;

   logic [38:0] sb [$];         // {dest, rd, result, nv}
   logic [15:0] lfsr = 16'd27122;

   fp_unit_wrapper i_fp_unit_wrapper (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // ------------------------------
   // Failure reporting
   // ------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else
         abort_run($sformatf("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act));
   endtask

   // ------------------------------
   // Stimulus helpers
   // ------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // One step per bit
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] pick_operand();
      logic [31:0] sel;
      sel = rand_bits(4);
      if (sel < 32'd10) return SPECIAL[sel[3:0]];
      return rand_bits(32);
   endfunction

   // Called 1 ns after an edge, returns 1 ns after the accepting edge
   task automatic send(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic [4:0] rd);
      instr_valid_i = 1'b1;
      instr_op_i    = op;
      rs1_data_i    = a;
      rs2_data_i    = b;
      rd_i          = rd;
      do @(posedge clk_i); while (stall_o);
      #1;
      instr_valid_i = 1'b0;
   endtask

   task automatic wait_empty();
      while (sb.size() != 0) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic logic [31:0] order_key(input logic [31:0] x);
      return x[31] ? ~x : {1'b1, x[30:0]};  // Monotonic, -0 below +0
   endfunction

   function automatic logic [9:0] class_mask(input logic [31:0] x);
      int idx;
      if (x[30:23] == 8'hFF && x[22:0] == 0) idx = x[31] ? 0 : 7;
      else if (x[30:23] == 8'hFF) idx = x[22] ? 9 : 8;
      else if (x[30:0] == 0) idx = x[31] ? 3 : 4;
      else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;
      else idx = x[31] ? 1 : 6;
      return 10'b1 << idx;
   endfunction

   function automatic void model(input fp_op_e op, input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] res, output logic nv);
      logic an, bn, sn, eq, lt;
      an  = (a[30:23] == 8'hFF) && (a[22:0] != 0);
      bn  = (b[30:23] == 8'hFF) && (b[22:0] != 0);
      sn  = (an && !a[22]) || (bn && !b[22]);
      eq  = (a == b) || (a[30:0] == 0 && b[30:0] == 0);
      lt  = !eq && (order_key(a) < order_key(b));
      res = '0;
      nv  = 1'b0;
      case (op)
         OP_SGNJ:  res = {b[31], a[30:0]};
         OP_SGNJN: res = {~b[31], a[30:0]};
         OP_SGNJX: res = {a[31] ^ b[31], a[30:0]};
         OP_MIN, OP_MAX: begin
            nv = sn;
            if (an && bn) res = 32'h7FC0_0000;
            else if (an) res = b;
            else if (bn) res = a;
            else if (op == OP_MIN) res = (order_key(a) <= order_key(b)) ? a : b;
            else res = (order_key(a) >= order_key(b)) ? a : b;
         end
         OP_FEQ: begin
            res = {31'd0, !an && !bn && eq};
            nv  = sn;
         end
         OP_FLT: begin
            res = {31'd0, !an && !bn && lt};
            nv  = an || bn;
         end
         OP_FLE: begin
            res = {31'd0, !an && !bn && (lt || eq)};
            nv  = an || bn;
         end
         OP_CLASS: res = {22'd0, class_mask(a)};
         default:  res = a;    // Both moves
      endcase
   endfunction

   // ------------------------------
   // Scoreboard and checks
   // ------------------------------
   always @(posedge clk_i) begin : scoreboard_check
      logic [38:0] exp_e;
      logic [31:0] res;
      logic        nv, to_int;
      if (arst_n_i && kill_i) begin
         sb.delete();   // In-flight work is dropped
      end else if (arst_n_i) begin
         assert (!(fp_wb_valid_o && int_wb_valid_o)) else
            abort_run("Both writeback valids are high in the same cycle");
         if ((fp_wb_valid_o || int_wb_valid_o) && !stall_wb_i) begin
            assert (sb.size() != 0) else
               abort_run("Writeback seen with no instruction pending");
            exp_e = sb.pop_front();
            check_value("int_wb_valid_o", {31'd0, exp_e[38]}, {31'd0, int_wb_valid_o});
            check_value("wb_rd_o", {27'd0, exp_e[37:33]}, {27'd0, wb_rd_o});
            check_value("wb_result_o", exp_e[32:1], wb_result_o);
            check_value("wb_nv_o", {31'd0, exp_e[0]}, {31'd0, wb_nv_o});
         end
         if (instr_valid_i && !stall_o) begin
            model(instr_op_i, rs1_data_i, rs2_data_i, res, nv);
            to_int = instr_op_i inside {OP_FEQ, OP_FLT, OP_FLE, OP_CLASS, OP_MV_F2X};
            sb.push_back({to_int, rd_i, res, nv});
         end
      end
   end

   // Lone instruction in an empty queue, counts edges to writeback
   task automatic check_latency(input fp_op_e op, input int expect_n);
      int n;
      wait_empty();
      send(op, 32'h4040_0000, 32'hBF80_0000, 5'd3);
      n = 0;
      do begin
         @(posedge clk_i);
         n++;
      end while (!(fp_wb_valid_o || int_wb_valid_o) && n < 10);
      check_value("writeback latency", expect_n, n);
      #1;
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      abort_run("Timeout: the run did not finish in the expected time");
   end

   initial begin : stimulus
      logic [31:0] held_res, opn;
      logic [4:0]  held_rd;
      logic        held_nv;
      int          drain_n;
      arst_n_i      = 1'b0;
      kill_i        = 1'b0;
      stall_wb_i    = 1'b0;
      instr_valid_i = 1'b0;
      instr_op_i    = OP_SGNJ;
      rs1_data_i    = '0;
      rs2_data_i    = '0;
      rd_i          = '0;
      repeat (3) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;

      // Every op over the special values
      for (int op = 0; op < 11; op++) begin
         for (int i = 0; i < 10; i++) begin
            send(fp_op_e'(op[3:0]), SPECIAL[i], SPECIAL[(i + op + 1) % 10], 5'(i + op));
         end
      end

      // Signed zeros and NaN pairs
      send(OP_MIN, 32'h0000_0000, 32'h8000_0000, 5'd10);
      send(OP_MAX, 32'h8000_0000, 32'h0000_0000, 5'd11);
      send(OP_MIN, 32'h7F80_0001, 32'hFFC0_0001, 5'd12);
      send(OP_MAX, 32'hFFC0_0001, 32'hFFC0_0001, 5'd13);
      send(OP_FEQ, 32'h0000_0000, 32'h8000_0000, 5'd14);

      check_latency(OP_SGNJX, 2);
      check_latency(OP_FLE, 3);
      send(OP_MIN, 32'h3F80_0000, 32'h8000_0000, 5'd1);  // Both lanes finish in one cycle
      send(OP_SGNJ, 32'h3F80_0000, 32'h8000_0000, 5'd2);

      // Back-pressure and full queue
      wait_empty();
      stall_wb_i = 1'b1;
      for (int i = 0; i < 4; i++) send(OP_MAX, pick_operand(), pick_operand(), 5'(i));
      assert (stall_o) else abort_run("stall_o stayed low with four pending instructions");
      while (!fp_wb_valid_o) begin
         @(posedge clk_i);
         #1;
      end
      held_res = wb_result_o;
      held_rd  = wb_rd_o;
      held_nv  = wb_nv_o;
      instr_valid_i = 1'b1;
      instr_op_i    = OP_CLASS;
      rs1_data_i    = 32'hFF80_0000;
      rs2_data_i    = 32'h0;
      rd_i          = 5'd20;
      repeat (3) begin
         @(posedge clk_i);
         assert (stall_o) else abort_run("Instruction accepted while the queue was full");
         check_value("fp_wb_valid_o", 32'd1, {31'd0, fp_wb_valid_o});
         check_value("wb_result_o", held_res, wb_result_o);
         check_value("wb_rd_o", {27'd0, held_rd}, {27'd0, wb_rd_o});
         check_value("wb_nv_o", {31'd0, held_nv}, {31'd0, wb_nv_o});
      end
      #1;
      stall_wb_i = 1'b0;
      do @(posedge clk_i); while (stall_o);
      #1;
      instr_valid_i = 1'b0;

      // Kill drops everything in flight, including the kill-edge instruction
      wait_empty();
      send(OP_FLT, 32'h3F80_0000, 32'h4000_0000, 5'd7);
      send(OP_SGNJN, 32'h3F80_0000, 32'h4000_0000, 5'd8);
      kill_i = 1'b1;
      send(OP_MAX, 32'h3F80_0000, 32'h4000_0000, 5'd9);
      kill_i = 1'b0;
      repeat (5) @(posedge clk_i);
      #1;
      send(OP_FEQ, 32'h3F80_0000, 32'h3F80_0000, 5'd9);

      // Random mix with random writeback stalls
      for (int i = 0; i < NUM_RANDOM; i++) begin
         stall_wb_i = stall_o ? 1'b0 : (rand_bits(2) == 0);
         opn = rand_bits(4) % 11;
         send(fp_op_e'(opn[3:0]), pick_operand(), pick_operand(), 5'(rand_bits(5)));
      end

      // Bounded drain, then a few idle cycles
      stall_wb_i = 1'b0;
      drain_n    = 0;
      while (sb.size() != 0 && drain_n < 4 * `FPU_QUEUE_DEPTH) begin
         @(posedge clk_i);
         #1;
         drain_n++;
      end
      repeat (5) @(posedge clk_i);

      if (sb.size() != 0) begin
         abort_run("Scoreboard not empty at the end of the run");
      end else begin
         $display("Regression passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: hw/fp_unit_wrapper.sv
// Top of the FP unit for non-computational single-precision ops
// Decodes each instruction, sends it to the sign or compare lane with a
// queue tag, and writes results back in program order
// stall_o is high while the completion queue is full
`default_nettype none

`include "fpu_config.svh"

module fp_unit_wrapper
   import fpu_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       kill_i,
   input  logic                       stall_wb_i,
   input  logic                       instr_valid_i,
   input  fp_op_e                     instr_op_i,
   input  logic [`FPU_XLEN-1:0]       rs1_data_i,
   input  logic [`FPU_XLEN-1:0]       rs2_data_i,
   input  logic [`FPU_REG_ADDR_W-1:0] rd_i,
   output logic                       stall_o,
   output logic                       fp_wb_valid_o,
   output logic                       int_wb_valid_o,
   output logic                       wb_nv_o,
   output logic [`FPU_REG_ADDR_W-1:0] wb_rd_o,
   output logic [`FPU_XLEN-1:0]       wb_result_o
);

   fp_lane_e              lane;
   fp_dest_e              dest;
   logic                  accept, queue_full;
   logic [`FPU_TAG_W-1:0] alloc_tag;

   logic                  sgn_done, cmp_done, cmp_nv;
   logic [`FPU_TAG_W-1:0] sgn_tag, cmp_tag;
   logic [`FPU_XLEN-1:0]  sgn_result, cmp_result;

   // ------------------------------
   // Decode
   // ------------------------------
   always_comb begin
      lane = LANE_CMP;
      dest = DEST_FP;
      case (instr_op_i)
         OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_MV_X2F: lane = LANE_SGN;
         OP_MV_F2X: begin
            lane = LANE_SGN;
            dest = DEST_INT;  // Raw bits to the integer file
         end
         OP_FEQ, OP_FLT, OP_FLE, OP_CLASS: dest = DEST_INT;
         default: ;  // Min/max stay on compare lane, FP file
      endcase
   end

   assign stall_o = queue_full;
   assign accept  = instr_valid_i & ~queue_full;

   // ------------------------------
   // Lanes and completion queue
   // ------------------------------
   fp_sign_lane i_fp_sign_lane (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .kill_i   (kill_i),
      .start_i  (accept && lane == LANE_SGN),
      .op_i     (instr_op_i),
      .a_i      (rs1_data_i),
      .b_i      (rs2_data_i),
      .tag_i    (alloc_tag),
      .done_o   (sgn_done),
      .tag_o    (sgn_tag),
      .result_o (sgn_result)
   );

   fp_compare_lane i_fp_compare_lane (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .kill_i   (kill_i),
      .start_i  (accept && lane == LANE_CMP),
      .op_i     (instr_op_i),
      .a_i      (rs1_data_i),
      .b_i      (rs2_data_i),
      .tag_i    (alloc_tag),
      .done_o   (cmp_done),
      .nv_o     (cmp_nv),
      .tag_o    (cmp_tag),
      .result_o (cmp_result)
   );

   fp_completion_queue i_fp_completion_queue (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .kill_i         (kill_i),
      .stall_wb_i     (stall_wb_i),
      .alloc_i        (accept),
      .alloc_dest_i   (dest),
      .alloc_rd_i     (rd_i),
      .alloc_tag_o    (alloc_tag),   // Same-cycle tag for the lane start
      .full_o         (queue_full),
      .sgn_done_i     (sgn_done),
      .sgn_tag_i      (sgn_tag),
      .sgn_result_i   (sgn_result),
      .cmp_done_i     (cmp_done),
      .cmp_nv_i       (cmp_nv),
      .cmp_tag_i      (cmp_tag),
      .cmp_result_i   (cmp_result),
      .fp_wb_valid_o  (fp_wb_valid_o),
      .int_wb_valid_o (int_wb_valid_o),
      .wb_nv_o        (wb_nv_o),
      .wb_rd_o        (wb_rd_o),
      .wb_result_o    (wb_result_o)
   );

endmodule

`default_nettype wire

// File: hw/fp_completion_queue.sv
// Reorder queue between the two lanes and writeback
// Allocates a tag per accepted instruction, collects results by tag and
// presents the head combinationally once it is done
// The head retires on an edge with stall_wb_i low, kill_i empties everything
`default_nettype none

`include "fpu_config.svh"

module fp_completion_queue
   import fpu_pkg::*;
(
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       kill_i,
   input  logic                       stall_wb_i,
   input  logic                       alloc_i,
   input  fp_dest_e                   alloc_dest_i,
   input  logic [`FPU_REG_ADDR_W-1:0] alloc_rd_i,
   output logic [`FPU_TAG_W-1:0]      alloc_tag_o,
   output logic                       full_o,
   input  logic                       sgn_done_i,
   input  logic [`FPU_TAG_W-1:0]      sgn_tag_i,
   input  logic [`FPU_XLEN-1:0]       sgn_result_i,
   input  logic                       cmp_done_i,
   input  logic                       cmp_nv_i,
   input  logic [`FPU_TAG_W-1:0]      cmp_tag_i,
   input  logic [`FPU_XLEN-1:0]       cmp_result_i,
   output logic                       fp_wb_valid_o,
   output logic                       int_wb_valid_o,
   output logic                       wb_nv_o,
   output logic [`FPU_REG_ADDR_W-1:0] wb_rd_o,
   output logic [`FPU_XLEN-1:0]       wb_result_o
);

   localparam int unsigned DEPTH = `FPU_QUEUE_DEPTH;
   localparam int unsigned CNT_W = `FPU_TAG_W + 1;

   logic [DEPTH-1:0]           busy_q, done_q, nv_q;
   fp_dest_e                   dest_q   [DEPTH];
   logic [`FPU_REG_ADDR_W-1:0] rd_q     [DEPTH];
   logic [`FPU_XLEN-1:0]       result_q [DEPTH];

   logic [`FPU_TAG_W-1:0] head_q, tail_q;
   logic [CNT_W-1:0]      count_q;
   logic                  alloc_ok, head_ready, retire;

   assign full_o      = (count_q == CNT_W'(DEPTH));
   assign alloc_ok    = alloc_i & ~full_o;
   assign alloc_tag_o = tail_q;  // Tag is the slot index
   assign head_ready  = busy_q[head_q] & done_q[head_q];
   assign retire      = head_ready & ~stall_wb_i;

   // ------------------------------
   // Pointers and entry state
   // ------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q  <= '0;
         done_q  <= '0;
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else if (kill_i) begin  // Flush, including any same-edge allocation
         busy_q  <= '0;
         done_q  <= '0;
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
      end else begin
         if (alloc_ok) begin
            busy_q[tail_q] <= 1'b1;
            done_q[tail_q] <= 1'b0;
            tail_q         <= tail_q + 1'b1;  // Wraps, depth is a power of two
         end
         if (sgn_done_i) done_q[sgn_tag_i] <= 1'b1;
         if (cmp_done_i) done_q[cmp_tag_i] <= 1'b1;
         if (retire) begin
            busy_q[head_q] <= 1'b0;
            done_q[head_q] <= 1'b0;
            head_q         <= head_q + 1'b1;
         end
         case ({alloc_ok, retire})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Entry payload, both lanes may write in one cycle
   always_ff @(posedge clk_i) begin
      if (alloc_ok) begin
         dest_q[tail_q] <= alloc_dest_i;
         rd_q[tail_q]   <= alloc_rd_i;
      end
      if (sgn_done_i) begin
         result_q[sgn_tag_i] <= sgn_result_i;
         nv_q[sgn_tag_i]     <= 1'b0;  // Sign lane never flags
      end
      if (cmp_done_i) begin
         result_q[cmp_tag_i] <= cmp_result_i;
         nv_q[cmp_tag_i]     <= cmp_nv_i;
      end
   end

   // Head presented as soon as it completes
   assign fp_wb_valid_o  = head_ready & (dest_q[head_q] == DEST_FP);
   assign int_wb_valid_o = head_ready & (dest_q[head_q] == DEST_INT);
   assign wb_rd_o        = rd_q[head_q];
   assign wb_result_o    = result_q[head_q];
   assign wb_nv_o        = nv_q[head_q];

endmodule

`default_nettype wire

// File: hw/fp_compare_lane.sv
// Two-stage lane for min/max, FEQ/FLT/FLE and FCLASS
// Stage one classifies both operands, stage two picks the result and NV
// done_o rises two cycles after start_i and carries the start tag back
`default_nettype none

`include "fpu_config.svh"

module fp_compare_lane
   import fpu_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  kill_i,
   input  logic                  start_i,
   input  fp_op_e                op_i,
   input  logic [`FPU_XLEN-1:0]  a_i,
   input  logic [`FPU_XLEN-1:0]  b_i,
   input  logic [`FPU_TAG_W-1:0] tag_i,
   output logic                  done_o,
   output logic                  nv_o,
   output logic [`FPU_TAG_W-1:0] tag_o,
   output logic [`FPU_XLEN-1:0]  result_o
);

   // One-hot FCLASS mask of a single-precision value
   function automatic logic [CLS_W-1:0] classify(input logic [`FPU_XLEN-1:0] x);
      logic [CLS_W-1:0] mask;
      logic             exp_zero;
      logic             exp_max;
      logic             man_zero;
      mask     = '0;
      exp_zero = (x[30:23] == 8'h00);
      exp_max  = (x[30:23] == 8'hFF);
      man_zero = (x[22:0] == 23'd0);
      if (exp_max && man_zero) begin
         mask[x[31] ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
      end else if (exp_max) begin
         mask[x[22] ? CLS_QNAN : CLS_SNAN] = 1'b1;  // Quiet bit is the mantissa MSB
      end else if (exp_zero && man_zero) begin
         mask[x[31] ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
      end else if (exp_zero) begin
         mask[x[31] ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
      end else begin
         mask[x[31] ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
      end
      return mask;
   endfunction

   logic                  s1_valid_q;
   fp_op_e                s1_op_q;
   logic [`FPU_TAG_W-1:0] s1_tag_q;
   logic [`FPU_XLEN-1:0]  s1_a_q, s1_b_q;
   logic [CLS_W-1:0]      s1_cls_a_q, s1_cls_b_q;

   logic                  a_nan, b_nan, any_nan, any_snan, both_zero;
   logic                  a_lt_b, a_eq_b;
   logic [`FPU_XLEN-1:0]  result_d;
   logic                  nv_d;

   // ------------------------------
   // Stage one
   // ------------------------------
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s1_valid_q <= 1'b0;
         done_o     <= 1'b0;
      end else begin
         s1_valid_q <= start_i & ~kill_i;
         done_o     <= s1_valid_q & ~kill_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         s1_op_q    <= op_i;
         s1_tag_q   <= tag_i;
         s1_a_q     <= a_i;
         s1_b_q     <= b_i;
         s1_cls_a_q <= classify(a_i);
         s1_cls_b_q <= classify(b_i);
      end
   end

   // ------------------------------
   // Stage two
   // ------------------------------
   assign a_nan     = s1_cls_a_q[CLS_SNAN] | s1_cls_a_q[CLS_QNAN];
   assign b_nan     = s1_cls_b_q[CLS_SNAN] | s1_cls_b_q[CLS_QNAN];
   assign any_nan   = a_nan | b_nan;
   assign any_snan  = s1_cls_a_q[CLS_SNAN] | s1_cls_b_q[CLS_SNAN];
   assign both_zero = (s1_cls_a_q[CLS_NEG_ZERO] | s1_cls_a_q[CLS_POS_ZERO])
                    & (s1_cls_b_q[CLS_NEG_ZERO] | s1_cls_b_q[CLS_POS_ZERO]);
   assign a_eq_b    = (s1_a_q == s1_b_q) | both_zero;

   // Sign-magnitude order, minus zero counts below plus zero here
   always_comb begin
      if (s1_a_q[31] != s1_b_q[31]) begin
         a_lt_b = s1_a_q[31];
      end else if (s1_a_q[31]) begin
         a_lt_b = (s1_b_q[30:0] < s1_a_q[30:0]);
      end else begin
         a_lt_b = (s1_a_q[30:0] < s1_b_q[30:0]);
      end
   end

   always_comb begin
      result_d = '0;
      nv_d     = 1'b0;
      case (s1_op_q)
         OP_MIN, OP_MAX: begin
            nv_d = any_snan;
            if (a_nan && b_nan)           result_d = CANONICAL_NAN;
            else if (a_nan)               result_d = s1_b_q;
            else if (b_nan)               result_d = s1_a_q;
            else if (s1_op_q == OP_MIN)   result_d = a_lt_b ? s1_a_q : s1_b_q;
            else                          result_d = a_lt_b ? s1_b_q : s1_a_q;
         end
         OP_FEQ: begin
            result_d[0] = ~any_nan & a_eq_b;
            nv_d        = any_snan;  // Quiet compare
         end
         OP_FLT: begin
            result_d[0] = ~any_nan & a_lt_b & ~both_zero;
            nv_d        = any_nan;
         end
         OP_FLE: begin
            result_d[0] = ~any_nan & (a_lt_b | a_eq_b);
            nv_d        = any_nan;
         end
         OP_CLASS: result_d = {{(`FPU_XLEN-CLS_W){1'b0}}, s1_cls_a_q};  // No flags
         default:  result_d = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (s1_valid_q) begin
         tag_o    <= s1_tag_q;
         result_o <= result_d;
         nv_o     <= nv_d;
      end
   end

endmodule

`default_nettype wire

// File: hw/fp_sign_lane.sv
// One-stage lane for sign injection and the two register moves
// Result and tag come out with done_o one cycle after start_i
`default_nettype none

`include "fpu_config.svh"

module fp_sign_lane
   import fpu_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  kill_i,
   input  logic                  start_i,
   input  fp_op_e                op_i,
   input  logic [`FPU_XLEN-1:0]  a_i,
   input  logic [`FPU_XLEN-1:0]  b_i,
   input  logic [`FPU_TAG_W-1:0] tag_i,
   output logic                  done_o,
   output logic [`FPU_TAG_W-1:0] tag_o,
   output logic [`FPU_XLEN-1:0]  result_o
);

   localparam int unsigned SIGN = `FPU_XLEN - 1;

   logic [`FPU_XLEN-1:0] result_d;

   // Magnitude always from a, only the sign changes
   always_comb begin
      case (op_i)
         OP_SGNJ:  result_d = {b_i[SIGN], a_i[SIGN-1:0]};
         OP_SGNJN: result_d = {~b_i[SIGN], a_i[SIGN-1:0]};
         OP_SGNJX: result_d = {a_i[SIGN] ^ b_i[SIGN], a_i[SIGN-1:0]};
         default:  result_d = a_i;  // FMV_X2F and FMV_F2X pass through
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= start_i & ~kill_i;  // Start on a kill edge is dropped
      end
   end

   // Payload
   always_ff @(posedge clk_i) begin
      if (start_i) begin
         tag_o    <= tag_i;
         result_o <= result_d;
      end
   end

endmodule

`default_nettype wire

// File: hw/fpu_pkg.sv
// Shared types and constants of the FP unit
// Import into any module that decodes operations or classifies operands
`default_nettype none

package fpu_pkg;

   // Decoded operation, also carried down to the lanes
   typedef enum logic [3:0] {
      OP_SGNJ,
      OP_SGNJN,
      OP_SGNJX,
      OP_MV_X2F,
      OP_MV_F2X,
      OP_MIN,
      OP_MAX,
      OP_FEQ,
      OP_FLT,
      OP_FLE,
      OP_CLASS
   } fp_op_e;

   typedef enum logic {LANE_SGN, LANE_CMP} fp_lane_e;  // Execution lane
   typedef enum logic {DEST_FP, DEST_INT} fp_dest_e;   // Writeback register file

   // FCLASS mask bits, RISC-V order
   localparam int unsigned CLS_NEG_INF  = 0;
   localparam int unsigned CLS_NEG_NORM = 1;
   localparam int unsigned CLS_NEG_SUB  = 2;
   localparam int unsigned CLS_NEG_ZERO = 3;
   localparam int unsigned CLS_POS_ZERO = 4;
   localparam int unsigned CLS_POS_SUB  = 5;
   localparam int unsigned CLS_POS_NORM = 6;
   localparam int unsigned CLS_POS_INF  = 7;
   localparam int unsigned CLS_SNAN     = 8;
   localparam int unsigned CLS_QNAN     = 9;
   localparam int unsigned CLS_W        = 10;

   localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;  // Quiet NaN for min/max

endpackage

`default_nettype wire

// File: include/fpu_config.svh
// Build-time sizes for the FP unit
// Include wherever data, register or queue widths are needed
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Operand and result width, single precision only
`define FPU_XLEN 32

// Destination register address width
`define FPU_REG_ADDR_W 5

// Completion queue entries, power of two (2, 4 or 8)
`define FPU_QUEUE_DEPTH 4

// Tag width, log2 of the queue depth
`define FPU_TAG_W 2

`endif
